// File: rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// Reorder buffer sizing

// Entry count, must be a power of two
`define ROB_DEPTH 16

// Tag width, log2 of ROB_DEPTH
`define ROB_TAG_W 4

// Writeback ports: 0 ALU, 1 MUL/DIV, 2 LSU
`define ROB_NUM_CPL 3

// Port index of the load/store unit
`define ROB_LSU_PORT 2

`endif

// File: rob_pkg.sv
`include "rob_params.svh"

package rob_pkg;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;  // Entry index, also the ROB tag

    // Decoded instruction from the decode stage
    typedef struct packed {
        logic [31:0] pc;         // Instruction address, becomes EPC on trap
        logic [4:0]  rd;         // Destination register
        logic        reg_write;  // Writes rd at commit
        logic        mem_write;  // Store
        logic        is_mret;    // Return from machine trap
        logic        dec_exc;    // Illegal or faulting at decode
    } dispatch_t;

    // Writeback from one execution unit
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;        // Entry being completed
        logic [31:0] value;      // Result
        logic [31:0] addr;       // Store address, LSU only
        logic        exc;        // Execution fault
    } complete_t;

    // Branch unit resolution
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;        // Branch entry
        logic        mispredict; // Younger entries are wrong path
        logic [31:0] target;     // Resolved target
    } branch_t;

    // One buffer slot
    typedef struct packed {
        logic        valid;      // Slot holds a live instruction
        logic        ready;      // Result present
        logic        exc;        // Trap at retire
        logic        reg_write;
        logic        mem_write;
        logic        is_mret;
        logic [4:0]  rd;
        logic [31:0] pc;
        logic [31:0] value;
        logic [31:0] addr;
    } rob_entry_t;

    // Retire record toward regfile and store buffer
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [4:0]  rd;
        logic        reg_write;
        logic [31:0] value;
        logic        mem_write;
        logic [31:0] addr;
    } commit_t;

    typedef enum logic [1:0] {
        RUN   = 2'd0,            // Normal in-order retire
        FLUSH = 2'd1             // One idle cycle after a trap
    } commit_state_e;

endpackage

// File: rob_pointers.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_pointers (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,        // Dispatch accepted
    input  logic              retire,       // Head leaves the buffer
    input  logic              clear_all,    // Trap flush
    input  logic              rollback,     // Mispredict recovery
    input  rob_pkg::rob_tag_t rollback_tag, // Branch tag
    output rob_pkg::rob_tag_t head,
    output rob_pkg::rob_tag_t tail,
    output logic              full,
    output logic              empty
);

    localparam logic [`ROB_TAG_W:0] depth_cnt = `ROB_DEPTH; // Occupancy when full

    rob_pkg::rob_tag_t       head_q;
    rob_pkg::rob_tag_t       tail_q;
    logic [`ROB_TAG_W:0]     count_q;      // One extra bit to tell full from empty
    rob_pkg::rob_tag_t       head_next;    // Head after this cycle's retire
    rob_pkg::rob_tag_t       rb_age;       // Branch distance from new head

    assign head_next = retire ? head_q + rob_pkg::rob_tag_t'(1) : head_q;
    assign rb_age    = rollback_tag - head_next; // Wraps mod depth

    always_ff @(posedge clk) begin
        if (rst || clear_all) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q <= head_next;              // Retire always honoured
            if (rollback) begin
                tail_q  <= rollback_tag + rob_pkg::rob_tag_t'(1); // Slot after branch
                count_q <= {1'b0, rb_age} + 1'b1;                 // Branch itself stays
            end else begin
                if (alloc) begin
                    tail_q <= tail_q + rob_pkg::rob_tag_t'(1);
                end
                case ({alloc, retire})
                    2'b10:   count_q <= count_q + 1'b1;
                    2'b01:   count_q <= count_q - 1'b1;
                    default: count_q <= count_q;   // Both or neither
                endcase
            end
        end
    end

    assign head  = head_q;
    assign tail  = tail_q;
    assign full  = (count_q == depth_cnt);
    assign empty = (count_q == '0);

endmodule

// File: rob_entry_array.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_entry_array (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc,                  // Write new entry
    input  rob_pkg::rob_tag_t    alloc_tag,              // Tail slot
    input  rob_pkg::dispatch_t   alloc_data,
    input  rob_pkg::complete_t   cpl [`ROB_NUM_CPL],     // Writeback ports
    input  rob_pkg::branch_t     br,
    input  rob_pkg::rob_tag_t    head,
    input  logic                 retire,                 // Drop head slot
    input  logic                 clear_all,              // Drop every slot
    output rob_pkg::rob_entry_t  head_entry
);

    rob_pkg::rob_entry_t       mem [`ROB_DEPTH];         // Slot payload and flags
    logic [`ROB_DEPTH-1:0]     valid_q;                  // Live slots
    logic [`ROB_DEPTH-1:0]     younger;                  // Wrong-path slots on mispredict
    rob_pkg::rob_tag_t         br_age;                   // Branch distance from head
    logic                      mispredict;

    assign mispredict = br.valid && br.mispredict;
    assign br_age     = br.tag - head;

    // Slot age from head against the branch age
    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            younger[i] = rob_pkg::rob_tag_t'(rob_pkg::rob_tag_t'(i) - head) > br_age;
        end
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst || clear_all) begin
            valid_q <= '0;                               // Empty after reset or trap
        end else begin
            if (mispredict) begin
                valid_q <= valid_q & ~younger;           // Squash wrong path
            end
            if (alloc) begin
                valid_q[alloc_tag] <= 1'b1;
            end
            if (retire) begin
                valid_q[head] <= 1'b0;                   // Head retired
            end
        end
    end

    // Payload, ready and exception
    always_ff @(posedge clk) begin
        if (alloc) begin
            mem[alloc_tag].ready     <= alloc_data.dec_exc; // Decode fault needs no completion
            mem[alloc_tag].exc       <= alloc_data.dec_exc;
            mem[alloc_tag].reg_write <= alloc_data.reg_write;
            mem[alloc_tag].mem_write <= alloc_data.mem_write;
            mem[alloc_tag].is_mret   <= alloc_data.is_mret;
            mem[alloc_tag].rd        <= alloc_data.rd;
            mem[alloc_tag].pc        <= alloc_data.pc;
            mem[alloc_tag].value     <= '0;
            mem[alloc_tag].addr      <= '0;
        end
        // Sources never collide on a tag in one cycle
        for (int p = 0; p < `ROB_NUM_CPL; p++) begin
            if (cpl[p].valid) begin
                mem[cpl[p].tag].value <= cpl[p].value;
                mem[cpl[p].tag].addr  <= cpl[p].addr;   // Only meaningful from LSU
                mem[cpl[p].tag].exc   <= cpl[p].exc;
                mem[cpl[p].tag].ready <= 1'b1;
            end
        end
        if (br.valid) begin
            mem[br.tag].value <= br.target;             // Branch result is its target
            mem[br.tag].ready <= 1'b1;
        end
    end

    // Head read with the live flag from valid_q
    always_comb begin
        head_entry       = mem[head];
        head_entry.valid = valid_q[head];
    end

endmodule

// File: rob_commit_fsm.sv
`timescale 1ns/1ps

module rob_commit_fsm (
    input  logic                 clk,
    input  logic                 rst,
    input  rob_pkg::rob_entry_t  head_entry,   // Oldest slot
    input  rob_pkg::rob_tag_t    head,
    output logic                 retire,       // Advance head this edge
    output logic                 clear_all,    // Trap flush
    output logic                 accepting,    // Dispatch allowed
    output rob_pkg::commit_t     commit,
    output logic                 trap_valid,
    output logic [31:0]          trap_epc,
    output rob_pkg::rob_tag_t    trap_tag,
    output logic                 mret_valid
);

    rob_pkg::commit_state_e state_q;
    logic                   head_done;          // Head valid with result
    logic                   take_trap;

    assign head_done = (state_q == rob_pkg::RUN) && head_entry.valid && head_entry.ready;
    assign retire    = head_done && !head_entry.exc;
    assign take_trap = head_done && head_entry.exc;
    assign clear_all = take_trap;
    assign accepting = (state_q == rob_pkg::RUN) && !take_trap; // Trap cycle blocks too

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= rob_pkg::RUN;
        end else begin
            case (state_q)
                rob_pkg::RUN: begin
                    if (take_trap) begin
                        state_q <= rob_pkg::FLUSH;
                    end
                end
                rob_pkg::FLUSH: begin
                    state_q <= rob_pkg::RUN;        // Single idle cycle
                end
                default: begin
                    state_q <= rob_pkg::RUN;
                end
            endcase
        end
    end

    // Retire record
    always_ff @(posedge clk) begin
        if (rst) begin
            commit     <= '0;
            mret_valid <= 1'b0;
        end else begin
            commit.valid     <= retire;
            commit.tag       <= head;
            commit.rd        <= head_entry.rd;
            commit.reg_write <= head_entry.reg_write && !head_entry.is_mret; // mret writes no rd
            commit.value     <= head_entry.value;
            commit.mem_write <= head_entry.mem_write;
            commit.addr      <= head_entry.addr;
            mret_valid       <= retire && head_entry.is_mret;
        end
    end

    // Trap report
    always_ff @(posedge clk) begin
        if (rst) begin
            trap_valid <= 1'b0;
        end else begin
            trap_valid <= take_trap;                // One-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (take_trap) begin
            trap_epc <= head_entry.pc;              // Precise EPC
            trap_tag <= head;
        end
    end

endmodule

// File: rob_core.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module rob_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  rob_pkg::dispatch_t  dispatch,
    output logic                dispatch_ready,
    output rob_pkg::rob_tag_t   dispatch_tag,          // Tag for the offered instruction
    input  rob_pkg::complete_t  cpl [`ROB_NUM_CPL],
    input  rob_pkg::branch_t    br,
    output rob_pkg::commit_t    commit,
    output logic                trap_valid,
    output logic [31:0]         trap_epc,
    output rob_pkg::rob_tag_t   trap_tag,
    output logic                mret_valid
);

    rob_pkg::rob_tag_t    head;
    rob_pkg::rob_tag_t    tail;
    rob_pkg::rob_entry_t  head_entry;
    logic                 full;
    logic                 alloc;
    logic                 retire;
    logic                 clear_all;
    logic                 accepting;
    logic                 rollback;

    assign rollback       = br.valid && br.mispredict;
    assign dispatch_ready = !full && accepting && !rollback; // Mispredict wins over dispatch
    assign alloc          = dispatch_ready && dispatch_valid;
    assign dispatch_tag   = tail;

    rob_pointers u_pointers (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .retire       (retire),
        .clear_all    (clear_all),
        .rollback     (rollback),
        .rollback_tag (br.tag),
        .head         (head),
        .tail         (tail),
        .full         (full),
        .empty        ()
    );

    rob_entry_array u_entries (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .alloc_tag  (tail),
        .alloc_data (dispatch),
        .cpl        (cpl),
        .br         (br),
        .head       (head),
        .retire     (retire),
        .clear_all  (clear_all),
        .head_entry (head_entry)
    );

    rob_commit_fsm u_commit (
        .clk        (clk),
        .rst        (rst),
        .head_entry (head_entry),
        .head       (head),
        .retire     (retire),
        .clear_all  (clear_all),
        .accepting  (accepting),
        .commit     (commit),
        .trap_valid (trap_valid),
        .trap_epc   (trap_epc),
        .trap_tag   (trap_tag),
        .mret_valid (mret_valid)
    );

endmodule

// File: tb_rob_core.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module tb_rob_core;

    localparam int num_tests   = 6;
    localparam int cycle_limit = num_tests * 64;    // Watchdog budget in clocks

    typedef struct packed {
        rob_pkg::commit_t rec;                      // Expected retire record
        logic [31:0]      pc;
        logic             is_mret;
        logic             exc;                      // Must trap and never commit
    } exp_t;

    logic                clk;
    logic                rst;
    logic                dispatch_valid;
    rob_pkg::dispatch_t  dispatch;
    logic                dispatch_ready;
    rob_pkg::rob_tag_t   dispatch_tag;
    rob_pkg::complete_t  cpl [`ROB_NUM_CPL];
    rob_pkg::branch_t    br;
    rob_pkg::commit_t    commit;
    logic                trap_valid;
    logic [31:0]         trap_epc;
    rob_pkg::rob_tag_t   trap_tag;
    logic                mret_valid;

    exp_t                exp_q [$];             // Oldest outstanding instruction first
    rob_pkg::rob_tag_t   exp_tail;              // Tag the next accepted dispatch must get
    logic [31:0]         lfsr = 32'hd8b20c33;
    int                  value_errors;
    int                  other_errors;
    rob_pkg::rob_tag_t   tags [16];
    int                  order [8];             // Completion order for the shuffle test

    rob_core dut (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .cpl            (cpl),
        .br             (br),
        .commit         (commit),
        .trap_valid     (trap_valid),
        .trap_epc       (trap_epc),
        .trap_tag       (trap_tag),
        .mret_valid     (mret_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    initial begin
        repeat (cycle_limit) @(posedge clk);
        $display("Timeout: run still going after %0d cycles", cycle_limit);
        $display("CHECKS FAILED");
        $finish;
    end

    no_commit_on_trap: assert property (@(posedge clk) disable iff (rst)
        !(commit.valid && trap_valid))
        else begin
            $display("Commit and trap reported in the same cycle at %0t", $time);
            other_errors++;
        end
    mret_with_commit: assert property (@(posedge clk) disable iff (rst)
        mret_valid |-> (commit.valid && !commit.reg_write))
        else begin
            $display("mret_valid without a matching commit record at %0t", $time);
            other_errors++;
        end
    block_on_mispredict: assert property (@(posedge clk) disable iff (rst)
        (br.valid && br.mispredict) |-> !dispatch_ready)
        else begin
            $display("Dispatch open during a mispredict at %0t", $time);
            other_errors++;
        end
    block_after_trap: assert property (@(posedge clk) disable iff (rst)
        trap_valid |-> !dispatch_ready)
        else begin
            $display("Dispatch open in the flush cycle at %0t", $time);
            other_errors++;
        end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0t ns: %s expected %h got %h", $time, name, expected, actual);
        value_errors++;
    endtask

    task automatic idle_inputs();
        dispatch_valid = 1'b0;
        dispatch       = '0;
        br             = '0;
        for (int p = 0; p < `ROB_NUM_CPL; p++) begin
            cpl[p] = '0;
        end
    endtask

    // Offer one instruction until accepted and record what it must retire as
    task automatic dispatch_instr(input logic [31:0] pc, input logic [4:0] rd,
                                  input logic reg_write, input logic mem_write,
                                  input logic is_mret, input logic dec_exc,
                                  output rob_pkg::rob_tag_t tag);
        rob_pkg::dispatch_t d;
        exp_t               e;
        int                 waited;
        logic               accepted;
        d        = '{pc: pc, rd: rd, reg_write: reg_write, mem_write: mem_write,
                     is_mret: is_mret, dec_exc: dec_exc};
        accepted = 1'b0;
        waited   = 0;
        tag      = '0;
        while (!accepted && waited < 64) begin
            @(negedge clk);
            idle_inputs();
            dispatch_valid = 1'b1;
            dispatch       = d;
            #1;                                 // Let ready and tag settle
            if (dispatch_ready) begin
                accepted        = 1'b1;
                tag             = dispatch_tag;
                assert (dispatch_tag == exp_tail)
                    else report_mismatch("dispatch_tag", 32'(exp_tail), 32'(dispatch_tag));
                e               = '0;
                e.rec.valid     = 1'b1;
                e.rec.tag       = exp_tail;
                e.rec.rd        = rd;
                e.rec.reg_write = reg_write && !is_mret;  // mret never writes rd
                e.rec.mem_write = mem_write;
                e.pc            = pc;
                e.is_mret       = is_mret;
                e.exc           = dec_exc;      // Traps with no completion
                exp_q.push_back(e);
                exp_tail        = exp_tail + rob_pkg::rob_tag_t'(1);
            end else begin
                waited++;
            end
        end
        if (!accepted) begin
            $display("Dispatch of pc %h not accepted within 64 cycles", pc);
            other_errors++;
        end
    endtask

    task automatic complete_tag(input int port, input rob_pkg::rob_tag_t tag,
                                input logic [31:0] value, input logic [31:0] addr,
                                input logic exc);
        rob_pkg::complete_t c;
        exp_t               e;
        @(negedge clk);
        idle_inputs();
        c = '{valid: 1'b1, tag: tag, value: value, addr: addr, exc: exc};
        cpl[port] = c;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i].rec.tag == tag) begin  // Squashed tags are absent
                e           = exp_q[i];
                e.rec.value = value;
                e.rec.addr  = addr;
                e.exc       = e.exc | exc;
                exp_q[i]    = e;
            end
        end
    endtask

    task automatic resolve_branch(input rob_pkg::rob_tag_t tag, input logic [31:0] target,
                                  input logic mispredict);
        exp_t e;
        int   idx;
        @(negedge clk);
        idle_inputs();
        br  = '{valid: 1'b1, tag: tag, mispredict: mispredict, target: target};
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i].rec.tag == tag) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("Branch tag %0d is not outstanding", tag);
            other_errors++;
        end else begin
            e           = exp_q[idx];
            e.rec.value = target;               // Branch retires its target
            exp_q[idx]  = e;
            if (mispredict) begin
                exp_tail = e.rec.tag + rob_pkg::rob_tag_t'(1); // Tail restarts after branch
            end
            while (mispredict && exp_q.size() > idx + 1) begin
                void'(exp_q.pop_back());        // Wrong path never retires
            end
        end
    endtask

    task automatic wait_queue_size(input int n);
        int waited;
        waited = 0;
        while (exp_q.size() > n && waited < 100) begin
            @(negedge clk);
            idle_inputs();
            #1;
            waited++;
        end
        if (exp_q.size() > n) begin
            $display("%0d instructions still outstanding after %0d cycles",
                     exp_q.size(), waited);
            other_errors++;
        end
    endtask

    // Retire and trap checker sampling registered outputs at the falling edge
    always @(negedge clk) begin
        exp_t e;
        if (!rst && commit.valid) begin
            if (exp_q.size() == 0) begin
                $display("Commit of tag %0d with nothing outstanding at %0t", commit.tag, $time);
                other_errors++;
            end else begin
                e = exp_q.pop_front();
                if (e.exc) begin
                    $display("Instruction at pc %h committed instead of trapping", e.pc);
                    other_errors++;
                end
                assert (commit.tag == e.rec.tag)
                    else report_mismatch("commit.tag", 32'(e.rec.tag), 32'(commit.tag));
                assert (commit.rd == e.rec.rd)
                    else report_mismatch("commit.rd", 32'(e.rec.rd), 32'(commit.rd));
                assert (commit.reg_write == e.rec.reg_write)
                    else report_mismatch("commit.reg_write", 32'(e.rec.reg_write),
                                         32'(commit.reg_write));
                assert (commit.value == e.rec.value)
                    else report_mismatch("commit.value", e.rec.value, commit.value);
                assert (commit.mem_write == e.rec.mem_write)
                    else report_mismatch("commit.mem_write", 32'(e.rec.mem_write),
                                         32'(commit.mem_write));
                assert (!e.rec.mem_write || commit.addr == e.rec.addr)
                    else report_mismatch("commit.addr", e.rec.addr, commit.addr);
                assert (mret_valid == e.is_mret)
                    else report_mismatch("mret_valid", 32'(e.is_mret), 32'(mret_valid));
            end
        end
        if (!rst && trap_valid) begin
            if (exp_q.size() == 0) begin
                $display("Trap with nothing outstanding at %0t", $time);
                other_errors++;
            end else begin
                e = exp_q[0];
                if (!e.exc) begin
                    $display("Trap on pc %h, which carries no exception", e.pc);
                    other_errors++;
                end
                assert (trap_epc == e.pc) else report_mismatch("trap_epc", e.pc, trap_epc);
                assert (trap_tag == e.rec.tag)
                    else report_mismatch("trap_tag", 32'(e.rec.tag), 32'(trap_tag));
                exp_q.delete();                 // Whole buffer flushed
                exp_tail = '0;                  // Both pointers back to slot 0
            end
        end
    end

    initial begin
        rob_pkg::rob_tag_t t;
        rob_pkg::rob_tag_t bt;
        int                j;
        int                tmp;
        int                port;
        logic [31:0]       v;
        value_errors = 0;
        other_errors = 0;
        exp_tail     = '0;
        rst          = 1'b1;
        idle_inputs();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Out-of-order completion with in-order retire
        for (int i = 0; i < 8; i++) begin
            dispatch_instr(32'h100 + 32'(4 * i), 5'(rand_bits(5)), 1'b1, 1'b0, 1'b0, 1'b0,
                           tags[i]);
            order[i] = i;
        end
        for (int i = 7; i > 0; i--) begin
            j        = int'(rand_bits(3) % 32'(i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 8; i++) begin
            port = int'(rand_bits(2) % 32'd3);
            v    = rand_bits(32);
            complete_tag(port, tags[order[i]], v, 32'h0, 1'b0);
        end
        wait_queue_size(0);

        // Full buffer then one slot freed
        for (int i = 0; i < 16; i++) begin
            dispatch_instr(32'h200 + 32'(4 * i), 5'(i + 1), 1'b1, 1'b0, 1'b0, 1'b0, tags[i]);
        end
        @(negedge clk);
        idle_inputs();
        #1;
        assert (!dispatch_ready) else report_mismatch("dispatch_ready", 32'd0, 32'd1);
        complete_tag(0, tags[0], 32'h0000_1111, 32'h0, 1'b0);
        wait_queue_size(15);
        assert (dispatch_ready) else report_mismatch("dispatch_ready", 32'd1, 32'd0);
        for (int i = 1; i < 16; i++) begin
            complete_tag(i % 3, tags[i], 32'h2000 + 32'(i), 32'h0, 1'b0);
        end
        wait_queue_size(0);

        // Store address and mret
        dispatch_instr(32'h300, 5'd0, 1'b0, 1'b1, 1'b0, 1'b0, t);
        complete_tag(`ROB_LSU_PORT, t, 32'h0, 32'h8000_0040, 1'b0);
        dispatch_instr(32'h304, 5'd3, 1'b1, 1'b0, 1'b1, 1'b0, t);
        complete_tag(0, t, 32'h0000_0abc, 32'h0, 1'b0);
        wait_queue_size(0);

        // Execution fault on the oldest entry
        dispatch_instr(32'h400, 5'd4, 1'b1, 1'b0, 1'b0, 1'b0, tags[0]);
        dispatch_instr(32'h404, 5'd5, 1'b1, 1'b0, 1'b0, 1'b0, tags[1]);
        dispatch_instr(32'h408, 5'd6, 1'b1, 1'b0, 1'b0, 1'b0, tags[2]);
        complete_tag(1, tags[1], 32'h0000_0b0b, 32'h0, 1'b0);   // Younger ones first
        complete_tag(2, tags[2], 32'h0000_0c0c, 32'h0, 1'b0);
        complete_tag(0, tags[0], 32'h0000_0a0a, 32'h0, 1'b1);
        wait_queue_size(0);
        dispatch_instr(32'h500, 5'd7, 1'b1, 1'b0, 1'b0, 1'b0, t);
        assert (t == '0) else report_mismatch("dispatch_tag", 32'd0, 32'(t));
        complete_tag(1, t, 32'h0000_5555, 32'h0, 1'b0);
        wait_queue_size(0);

        // Mispredicted branch with wrong-path entries behind it
        dispatch_instr(32'h600, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0, bt);
        for (int i = 0; i < 3; i++) begin
            dispatch_instr(32'h604 + 32'(4 * i), 5'(8 + i), 1'b1, 1'b0, 1'b0, 1'b0, tags[i]);
        end
        resolve_branch(bt, 32'h0000_0800, 1'b1);
        for (int i = 0; i < 3; i++) begin
            complete_tag(i, tags[i], 32'hdead_0000 + 32'(i), 32'h0, 1'b0);
        end
        @(negedge clk);
        idle_inputs();
        #1;
        assert (dispatch_tag == rob_pkg::rob_tag_t'(bt + 1))
            else report_mismatch("dispatch_tag", 32'(rob_pkg::rob_tag_t'(bt + 1)),
                                 32'(dispatch_tag));
        wait_queue_size(0);

        // Decode exception traps at the head with no completion
        dispatch_instr(32'h700, 5'd11, 1'b1, 1'b0, 1'b0, 1'b0, t);
        dispatch_instr(32'h704, 5'd12, 1'b1, 1'b0, 1'b0, 1'b1, tags[0]);
        dispatch_instr(32'h708, 5'd13, 1'b1, 1'b0, 1'b0, 1'b0, tags[1]);
        complete_tag(0, t, 32'h0000_7777, 32'h0, 1'b0);
        wait_queue_size(0);
        repeat (4) @(negedge clk);

        $display("Checks done: %0d value mismatches, %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: rob_core.f
+incdir+.
rob_pkg.sv
rob_pointers.sv
rob_entry_array.sv
rob_commit_fsm.sv
rob_core.sv
tb_rob_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the reorder buffer testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rob_core \
    -f rob_core.f -o sim_rob > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_rob > sim.log 2>&1 ; cat sim.log

grep -q "ALL CHECKS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
